//--- rtl/mmc5_cfg.svh
// Offsets use the compact {A9, A6..A0} form of the $5100-$5206 window and unlisted addresses decode to MMC5_R_NONE
`ifndef MMC5_CFG_SVH
`define MMC5_CFG_SVH

`define MMC5_REG_BASE      6'b010100   // A15..A10 of $5000-$53FF
`define MMC5_EXRAM_BASE    6'b010111   // A15..A10 of $5C00-$5FFF
`define MMC5_R_NONE        8'hFF       // No register at this address

`define MMC5_R_PRG_MODE    8'h00       // $5100
`define MMC5_R_CHR_MODE    8'h01
`define MMC5_R_PROT1       8'h02
`define MMC5_R_PROT2       8'h03
`define MMC5_R_EXRAM_MODE  8'h04
`define MMC5_R_MIRROR      8'h05
`define MMC5_R_FILL_TILE   8'h06
`define MMC5_R_FILL_ATTR   8'h07
`define MMC5_R_PRG_RAM     8'h13       // $5113
`define MMC5_R_PRG_BANK0   8'h14
`define MMC5_R_PRG_BANK1   8'h15
`define MMC5_R_PRG_BANK2   8'h16
`define MMC5_R_PRG_BANK3   8'h17       // Always ROM
`define MMC5_R_CHR_BANK0   8'h20       // $5120, twelve banks follow
`define MMC5_CHR_BANKS     12
`define MMC5_R_CHR_UPPER   8'h30
`define MMC5_R_IRQ_LINE    8'h83       // $5203
`define MMC5_R_IRQ_STATUS  8'h84       // $5204 write enable, read status
`define MMC5_R_MUL_LO      8'h85
`define MMC5_R_MUL_HI      8'h86

`define MMC5_PROT1_KEY     2'b10
`define MMC5_PROT2_KEY     2'b01
`define MMC5_EXRAM_DEPTH   1024
`define MMC5_EXRAM_AW      10
`define MMC5_LAST_LINE     8'd239
`define MMC5_PRG_RAM_PAGE  6'b11_1100  // Upper page bits of PRG-RAM in cart space
`define MMC5_CHR_PAGE      2'b10       // CHR ROM region of cart space
`define MMC5_PRG_MODE_RST  2'd3
`define MMC5_PRG_BANK3_RST 7'h7F

`endif

//--- rtl/mmc5_pkg.sv
// Shared bus and register types only; widths follow the cart layout with 22-bit PRG and CHR space
package mmc5_pkg;

	// CPU side as seen by every block
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        read;
		logic        write;
		logic [7:0]  reg_off;   // Compact offset or MMC5_R_NONE
	} cpu_bus_t;

	// PPU status levels
	typedef struct packed {
		logic       in_frame;
		logic       sprite16;   // 8x16 sprites on
		logic [8:0] cycle;
		logic [8:0] scanline;
	} ppu_status_t;

	// Full programmed state, driven by the register block
	typedef struct packed {
		logic [1:0]        prg_mode;
		logic [1:0]        chr_mode;
		logic              prot1;      // $5102 key matched
		logic              prot2;      // $5103 key matched
		logic [1:0]        exram_mode;
		logic [7:0]        mirroring;  // Two bits per quadrant
		logic [7:0]        fill_tile;
		logic [1:0]        fill_attr;
		logic [2:0]        prg_ram_bank;
		logic [2:0][7:0]   prg_bank;   // $5114-$5116, bit 7 set means ROM
		logic [6:0]        prg_bank3;
		logic [11:0][9:0]  chr_bank;
		logic [1:0]        chr_upper;
		logic [7:0]        irq_line;
		logic              irq_enable;
		logic              chr_last;   // Last CHR set written
	} mmc5_regs_t;

	// PRG selector byte, bit 7 picks the view
	typedef union packed {
		struct packed {
			logic       is_rom;
			logic [6:0] bank;
		} rom;
		struct packed {
			logic       is_rom;
			logic [3:0] unused;
			logic [2:0] bank;
		} ram;
	} prg_sel_u;

	typedef enum logic {
		SET_SPRITE = 1'b0,  // $5120-$5127
		SET_BG     = 1'b1   // $5128-$512B
	} chr_set_e;

	typedef enum logic [1:0] {
		NT_INT_A  = 2'd0,
		NT_INT_B  = 2'd1,
		NT_EXRAM  = 2'd2,
		NT_FILL   = 2'd3
	} nt_src_e;

endpackage

//--- rtl/mmc5_regs.sv
// Writes land on a ce clock with write high; split, audio and $5010 registers are not decoded
`include "mmc5_cfg.svh"

module mmc5_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ce,
	input  mmc5_pkg::cpu_bus_t   cpu,
	input  mmc5_pkg::ppu_status_t ppu,
	input  logic [7:0]           exram_rdata,   // One clock behind the address
	input  logic                 irq_pending,
	output mmc5_pkg::mmc5_regs_t regs,
	output logic                 status_read,   // Pulse on a $5204 read
	output logic [7:0]           cpu_rdata,
	output logic                 cpu_rdata_valid
);

	logic [7:0]  mul_a, mul_b;   // Multiplier factors
	logic [15:0] product;
	logic        sprite16_q;     // For the 8x16 to 8x8 edge
	logic        wr_en;
	logic        in_exram;

	assign wr_en    = ce && cpu.write;
	assign in_exram = (cpu.addr[15:10] == `MMC5_EXRAM_BASE);
	assign product  = mul_a * mul_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			regs            <= '0;
			regs.prg_mode   <= `MMC5_PRG_MODE_RST;
			regs.prg_bank3  <= `MMC5_PRG_BANK3_RST;
			mul_a           <= '0;
			mul_b           <= '0;
			sprite16_q      <= 1'b0;
		end else begin
			if (wr_en) begin
				case (cpu.reg_off)
					`MMC5_R_PRG_MODE:   regs.prg_mode <= cpu.wdata[1:0];
					`MMC5_R_CHR_MODE:   regs.chr_mode <= cpu.wdata[1:0];
					`MMC5_R_PROT1:      regs.prot1 <= (cpu.wdata[1:0] == `MMC5_PROT1_KEY);
					`MMC5_R_PROT2:      regs.prot2 <= (cpu.wdata[1:0] == `MMC5_PROT2_KEY);
					`MMC5_R_EXRAM_MODE: regs.exram_mode <= cpu.wdata[1:0];
					`MMC5_R_MIRROR:     regs.mirroring <= cpu.wdata;
					`MMC5_R_FILL_TILE:  regs.fill_tile <= cpu.wdata;
					`MMC5_R_FILL_ATTR:  regs.fill_attr <= cpu.wdata[1:0];
					`MMC5_R_PRG_RAM:    regs.prg_ram_bank <= cpu.wdata[2:0];
					`MMC5_R_PRG_BANK0:  regs.prg_bank[0] <= cpu.wdata;
					`MMC5_R_PRG_BANK1:  regs.prg_bank[1] <= cpu.wdata;
					`MMC5_R_PRG_BANK2:  regs.prg_bank[2] <= cpu.wdata;
					`MMC5_R_PRG_BANK3:  regs.prg_bank3 <= cpu.wdata[6:0];   // Bit 7 ignored
					`MMC5_R_CHR_UPPER:  regs.chr_upper <= cpu.wdata[1:0];
					`MMC5_R_IRQ_LINE:   regs.irq_line <= cpu.wdata;
					`MMC5_R_IRQ_STATUS: regs.irq_enable <= cpu.wdata[7];
					`MMC5_R_MUL_LO:     mul_a <= cpu.wdata;
					`MMC5_R_MUL_HI:     mul_b <= cpu.wdata;
					default: ;
				endcase

				// CHR banks take the upper bits latched at write time
				if (cpu.reg_off[7:4] == `MMC5_R_CHR_BANK0 >> 4 &&
						cpu.reg_off[3:0] < 4'(`MMC5_CHR_BANKS))
					regs.chr_bank[cpu.reg_off[3:0]] <= {regs.chr_upper, cpu.wdata};

				// Set choice remembered only while 8x16 is on
				if (cpu.reg_off[7:4] == `MMC5_R_CHR_BANK0 >> 4)
					regs.chr_last <= cpu.reg_off[3] & ppu.sprite16;
			end

			sprite16_q <= ppu.sprite16;
			if (sprite16_q && !ppu.sprite16)
				regs.chr_last <= 1'b0;   // Back to 8x8 sprites
		end
	end

	assign status_read = ce && cpu.read && (cpu.reg_off == `MMC5_R_IRQ_STATUS);

	// Read-back, open bus unless something answers
	always_comb begin
		cpu_rdata       = 8'hFF;
		cpu_rdata_valid = 1'b0;
		if (in_exram && regs.exram_mode[1]) begin
			cpu_rdata       = exram_rdata;   // Modes 2/3 only
			cpu_rdata_valid = cpu.read;
		end else if (cpu.reg_off == `MMC5_R_IRQ_STATUS) begin
			cpu_rdata       = {irq_pending, ppu.in_frame, 6'b11_1111};
			cpu_rdata_valid = cpu.read;
		end else if (cpu.reg_off == `MMC5_R_MUL_LO) begin
			cpu_rdata       = product[7:0];
			cpu_rdata_valid = cpu.read;
		end else if (cpu.reg_off == `MMC5_R_MUL_HI) begin
			cpu_rdata       = product[15:8];
			cpu_rdata_valid = cpu.read;
		end
	end

endmodule

//--- rtl/mmc5_prg_map.sv
// PRG map in 8 KB pages, pure combinational; PRG-RAM is limited to eight banks at a fixed page
`include "mmc5_cfg.svh"

module mmc5_prg_map (
	input  mmc5_pkg::mmc5_regs_t regs,
	input  logic [15:0]          cpu_addr,
	input  logic                 cpu_write,
	output logic [21:0]          prg_addr,
	output logic                 prg_allow
);

	mmc5_pkg::prg_sel_u sel;
	logic [8:0]         page;   // 8 KB page in cart space
	logic               ram_we;

	always_comb begin
		sel = {1'b1, regs.prg_bank3};   // Fixed top bank by default
		casez ({regs.prg_mode, cpu_addr[15:13]})
			5'b??_0??: begin   // $6000-$7FFF in every mode
				sel.ram.is_rom = 1'b0;
				sel.ram.unused = '0;
				sel.ram.bank   = regs.prg_ram_bank;
			end
			5'b00_1??: sel = {1'b1, regs.prg_bank3[6:2], cpu_addr[14:13]};    // 32 KB
			5'b01_10?: sel = {regs.prg_bank[1][7:1], cpu_addr[13]};           // 16 KB
			5'b01_11?: sel = {1'b1, regs.prg_bank3[6:1], cpu_addr[13]};
			5'b10_10?: sel = {regs.prg_bank[1][7:1], cpu_addr[13]};
			5'b10_110: sel = regs.prg_bank[2];                                // 8 KB
			5'b10_111: sel = {1'b1, regs.prg_bank3};
			5'b11_100: sel = regs.prg_bank[0];
			5'b11_101: sel = regs.prg_bank[1];
			5'b11_110: sel = regs.prg_bank[2];
			5'b11_111: sel = {1'b1, regs.prg_bank3};
			default: ;
		endcase
	end

	assign page     = sel.rom.is_rom ? {2'b00, sel.rom.bank} : {`MMC5_PRG_RAM_PAGE, sel.ram.bank};
	assign prg_addr = {page, cpu_addr[12:0]};

	// Both keys needed before PRG-RAM takes a write
	assign ram_we    = regs.prot1 && regs.prot2;
	assign prg_allow = (cpu_addr >= 16'h6000) &&
		(!cpu_write || (!sel.ram.is_rom && ram_we));

endmodule

//--- rtl/mmc5_chr_map.sv
// CHR map in 1 KB pages, pure combinational; no split or extended-attribute page override
`include "mmc5_cfg.svh"

module mmc5_chr_map (
	input  mmc5_pkg::mmc5_regs_t  regs,
	input  mmc5_pkg::ppu_status_t ppu,
	input  logic [13:0]           chr_addr_in,
	output logic [21:0]           chr_addr
);

	mmc5_pkg::chr_set_e set;
	logic               is_bg_fetch;
	logic [9:0]         chrsel;   // 1 KB page

	// Sprite fetches sit at cycles 256-319
	assign is_bg_fetch = !(ppu.cycle[8] && !ppu.cycle[6]);

	// Split sets only with 8x16 sprites while rendering
	always_comb begin
		if (ppu.sprite16 && ppu.in_frame)
			set = is_bg_fetch ? mmc5_pkg::SET_BG : mmc5_pkg::SET_SPRITE;
		else
			set = mmc5_pkg::chr_set_e'(regs.chr_last);
	end

	always_comb begin
		chrsel = regs.chr_bank[0];
		casez ({regs.chr_mode, chr_addr_in[12:10], set})
			// 8 KB
			6'b00_???_0: chrsel = {regs.chr_bank[7][6:0], chr_addr_in[12:10]};
			6'b00_???_1: chrsel = {regs.chr_bank[11][6:0], chr_addr_in[12:10]};
			// 4 KB, background set mirrors into both halves
			6'b01_0??_0: chrsel = {regs.chr_bank[3][7:0], chr_addr_in[11:10]};
			6'b01_1??_0: chrsel = {regs.chr_bank[7][7:0], chr_addr_in[11:10]};
			6'b01_???_1: chrsel = {regs.chr_bank[11][7:0], chr_addr_in[11:10]};
			// 2 KB
			6'b10_00?_0: chrsel = {regs.chr_bank[1][8:0], chr_addr_in[10]};
			6'b10_01?_0: chrsel = {regs.chr_bank[3][8:0], chr_addr_in[10]};
			6'b10_10?_0: chrsel = {regs.chr_bank[5][8:0], chr_addr_in[10]};
			6'b10_11?_0: chrsel = {regs.chr_bank[7][8:0], chr_addr_in[10]};
			6'b10_?0?_1: chrsel = {regs.chr_bank[9][8:0], chr_addr_in[10]};
			6'b10_?1?_1: chrsel = {regs.chr_bank[11][8:0], chr_addr_in[10]};
			// 1 KB, sprite set uses 0-7 and background set 8-11
			6'b11_???_0: chrsel = regs.chr_bank[chr_addr_in[12:10]];
			6'b11_???_1: chrsel = regs.chr_bank[{2'b10, chr_addr_in[11:10]}];
			default: ;
		endcase
	end

	assign chr_addr = {`MMC5_CHR_PAGE, chrsel, chr_addr_in[9:0]};

endmodule

//--- rtl/mmc5_exram.sv
// 1 KB ExRAM with one-clock read latency; out of frame the CHR data is the last nametable read
`include "mmc5_cfg.svh"

module mmc5_exram (
	input  logic                  clk,
	input  logic                  ce,
	input  logic                  ppu_ce,
	input  mmc5_pkg::mmc5_regs_t  regs,
	input  mmc5_pkg::cpu_bus_t    cpu,
	input  mmc5_pkg::ppu_status_t ppu,
	input  logic [13:0]           chr_addr_in,
	input  logic                  chr_write,
	input  logic [7:0]            chr_wdata,
	output logic [7:0]            exram_rdata,
	output logic [7:0]            chr_rdata,
	output logic                  chr_rdata_valid,
	output logic                  vram_a10,
	output logic                  vram_ce
);

	logic [7:0]                  mem [`MMC5_EXRAM_DEPTH];
	logic [`MMC5_EXRAM_AW-1:0]   raddr;
	logic [7:0]                  rd_q;       // Last word read
	logic [7:0]                  nt_data;    // ExRAM as nametable
	mmc5_pkg::nt_src_e           src;
	logic                        ppu_we, cpu_we;

	// Quadrant source from A11..A10
	assign src = mmc5_pkg::nt_src_e'(regs.mirroring[{chr_addr_in[11:10], 1'b0} +: 2]);

	assign ppu_we = ppu_ce && chr_write && !ppu.in_frame && !regs.exram_mode[1] &&
		(src == mmc5_pkg::NT_EXRAM) && chr_addr_in[13];
	assign cpu_we = ce && cpu.write && (cpu.addr[15:10] == `MMC5_EXRAM_BASE);

	assign raddr = regs.exram_mode[1] ? cpu.addr[9:0] : chr_addr_in[9:0];

	always_ff @(posedge clk) begin
		rd_q <= mem[raddr];
		if (regs.exram_mode != 2'd3) begin   // Mode 3 is read-only
			if (ppu_we)
				mem[chr_addr_in[9:0]] <= chr_wdata;
			else if (cpu_we)
				mem[cpu.addr[9:0]] <= (regs.exram_mode[1] || ppu.in_frame) ? cpu.wdata : 8'h00;
		end
	end

	assign exram_rdata = rd_q;
	assign nt_data     = regs.exram_mode[1] ? 8'h00 : rd_q;   // RAM modes hide it from the PPU

	always_comb begin
		chr_rdata = nt_data;
		if (ppu.in_frame && src == mmc5_pkg::NT_FILL)
			chr_rdata = ppu.cycle[1] ? {4{regs.fill_attr}} : regs.fill_tile;   // Attr on odd pair
	end

	assign chr_rdata_valid = chr_addr_in[13] && src[1];   // ExRAM or fill answers
	assign vram_a10        = src[0];
	assign vram_ce         = chr_addr_in[13] && !src[1];

endmodule

//--- rtl/mmc5_scanline_irq.sv
// Scanline IRQ on lines 1-239; the scanline change is seen only on ppu_ce clocks
`include "mmc5_cfg.svh"

module mmc5_scanline_irq (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  logic                  ppu_ce,
	input  mmc5_pkg::ppu_status_t ppu,
	input  logic [7:0]            irq_line,
	input  logic                  irq_enable,
	input  logic                  status_read,
	output logic                  irq_pending,
	output logic                  irq
);

	logic last_sl0;    // Scanline LSB at the last ppu_ce
	logic new_line;
	logic trig;
	logic rd_clear;

	assign new_line = ppu_ce && (ppu.scanline[0] != last_sl0);
	assign trig     = (irq_line != 8'd0) && (irq_line <= `MMC5_LAST_LINE) &&
		(ppu.scanline == {1'b0, irq_line});
	assign rd_clear = ce && status_read;   // $5204 read acknowledges

	always_ff @(posedge clk) begin
		if (reset) begin
			irq_pending <= 1'b0;
			last_sl0    <= 1'b0;
			irq         <= 1'b0;
		end else begin
			if (ppu_ce)
				last_sl0 <= ppu.scanline[0];

			if (rd_clear || !ppu.in_frame)
				irq_pending <= 1'b0;   // Also cleared in vblank
			else if (new_line && trig)
				irq_pending <= 1'b1;

			irq <= irq_pending && irq_enable;   // One cycle behind pending
		end
	end

endmodule

//--- rtl/mmc5_top.sv
// Mapper core without split, audio or tristate outputs; reset stands in for the enable pin
`include "mmc5_cfg.svh"

module mmc5_top (
	input  logic        clk,
	input  logic        reset,
	// CPU side
	input  logic        ce,           // M2 strobe
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_read,
	input  logic        cpu_write,
	output logic [21:0] prg_addr,
	output logic        prg_allow,
	output logic [7:0]  cpu_rdata,
	output logic        cpu_rdata_valid,
	// PPU side
	input  logic        ppu_ce,
	input  logic        ppu_in_frame,
	input  logic        ppu_sprite16,
	input  logic [8:0]  ppu_cycle,
	input  logic [8:0]  ppu_scanline,
	input  logic [13:0] chr_addr_in,
	input  logic        chr_write,
	input  logic [7:0]  chr_wdata,
	output logic [21:0] chr_addr,
	output logic [7:0]  chr_rdata,
	output logic        chr_rdata_valid,
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq
);

	mmc5_pkg::cpu_bus_t    cpu;
	mmc5_pkg::ppu_status_t ppu;
	mmc5_pkg::mmc5_regs_t  regs;
	logic [7:0]            exram_rdata;
	logic                  irq_pending;
	logic                  status_read;
	logic                  in_win;   // $5100-$517F or $5200-$527F

	assign in_win = (cpu_addr[15:10] == `MMC5_REG_BASE) && !cpu_addr[7] &&
		(cpu_addr[9:8] == 2'b01 || cpu_addr[9:8] == 2'b10);

	assign cpu.addr    = cpu_addr;
	assign cpu.wdata   = cpu_wdata;
	assign cpu.read    = cpu_read;
	assign cpu.write   = cpu_write;
	assign cpu.reg_off = in_win ? {cpu_addr[9], cpu_addr[6:0]} : `MMC5_R_NONE;

	assign ppu.in_frame = ppu_in_frame;
	assign ppu.sprite16 = ppu_sprite16;
	assign ppu.cycle    = ppu_cycle;
	assign ppu.scanline = ppu_scanline;

	mmc5_regs u_regs (
		.clk(clk), .reset(reset), .ce(ce), .cpu(cpu), .ppu(ppu),
		.exram_rdata(exram_rdata), .irq_pending(irq_pending), .regs(regs),
		.status_read(status_read), .cpu_rdata(cpu_rdata), .cpu_rdata_valid(cpu_rdata_valid)
	);

	mmc5_prg_map u_prg_map (
		.regs(regs), .cpu_addr(cpu_addr), .cpu_write(cpu_write),
		.prg_addr(prg_addr), .prg_allow(prg_allow)
	);

	mmc5_chr_map u_chr_map (
		.regs(regs), .ppu(ppu), .chr_addr_in(chr_addr_in), .chr_addr(chr_addr)
	);

	mmc5_exram u_exram (
		.clk(clk), .ce(ce), .ppu_ce(ppu_ce), .regs(regs), .cpu(cpu), .ppu(ppu),
		.chr_addr_in(chr_addr_in), .chr_write(chr_write), .chr_wdata(chr_wdata),
		.exram_rdata(exram_rdata), .chr_rdata(chr_rdata), .chr_rdata_valid(chr_rdata_valid),
		.vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	mmc5_scanline_irq u_scanline_irq (
		.clk(clk), .reset(reset), .ce(ce), .ppu_ce(ppu_ce), .ppu(ppu),
		.irq_line(regs.irq_line), .irq_enable(regs.irq_enable), .status_read(status_read),
		.irq_pending(irq_pending), .irq(irq)
	);

endmodule

//--- dv/mmc5_asserts.sv
// Port-level properties of the mapper top; irq_en is taken from the register struct by the bind
module mmc5_asserts (
	input logic        clk,
	input logic        reset,
	input logic        irq,
	input logic        irq_en,
	input logic        cpu_rdata_valid,
	input logic        prg_allow,
	input logic [15:0] cpu_addr,
	input logic        cpu_write
);
	timeunit 1ns;
	timeprecision 100ps;

	// irq is registered from pending and enable
	irq_needs_enable: assert property (@(posedge clk) disable iff (reset) irq |-> $past(irq_en))
		else $error("irq high while the interrupt was disabled");

	// First clock out of reset
	valid_low_after_reset: assert property (@(posedge clk) $past(reset) && !reset |-> !cpu_rdata_valid)
		else $error("read data valid right after reset");

	no_write_below_6000: assert property (@(posedge clk) disable iff (reset)
		(cpu_write && cpu_addr < 16'h6000) |-> !prg_allow)
		else $error("PRG write allowed below $6000");

endmodule

bind mmc5_top mmc5_asserts u_asserts (
	.clk(clk), .reset(reset), .irq(irq), .irq_en(regs.irq_enable),
	.cpu_rdata_valid(cpu_rdata_valid), .prg_allow(prg_allow),
	.cpu_addr(cpu_addr), .cpu_write(cpu_write)
);

//--- dv/mmc5_tb.sv
// Drives the mapper from a register shadow; needs rtl/ on the include path for the RTL headers only
module mmc5_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_CYCLES = 20000;   // Whole run takes about 1700 cycles

	typedef struct packed {
		logic [21:0] prg_addr;
		logic        prg_allow;
		logic [21:0] chr_addr;
		logic        vram_a10;
		logic        vram_ce;
		logic        chr_valid;
		logic        fill;        // Fill data expected on chr_rdata
		logic [7:0]  fill_data;
	} exp_t;

	logic clk, reset, ce, cpu_read, cpu_write;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata, cpu_rdata;
	logic [21:0] prg_addr, chr_addr;
	logic        prg_allow, cpu_rdata_valid, irq;
	logic        ppu_ce, ppu_in_frame, ppu_sprite16, chr_write;
	logic [8:0]  ppu_cycle, ppu_scanline;
	logic [13:0] chr_addr_in;
	logic [7:0]  chr_wdata, chr_rdata;
	logic        chr_rdata_valid, vram_a10, vram_ce;

	// Register shadow
	logic [1:0] prg_mode, chr_mode, fill_attr, chr_upper;
	logic       key1, key2, irq_en, chr_last;
	logic [7:0] mirroring, fill_tile, irq_line;
	logic [2:0] ram_bank;
	logic [7:0] prg_bank [3];
	logic [6:0] bank3;
	logic [9:0] chr_bank [12];

	integer seed = 32'h47f9_e591;
	int     cycles = 0;
	logic   cmp_en = 1'b0;   // Compare process active

	mmc5_top u_mmc5_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
			$display("Simulation failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
		if (act !== exp) begin
			$display("Fail at %0t ns: %s, got %h expected %h", $time, msg, act, exp);
			$display("Simulation failed");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	// Expected mapping from the shadow and the current inputs
	function automatic exp_t ref_mmc5(input logic [15:0] a, input logic wr, input logic [13:0] ca,
			input logic frame, input logic spr16, input logic [8:0] cyc);
		exp_t       e;
		logic [7:0] s;
		logic [8:0] page;
		logic       set;
		logic [9:0] sel;
		logic [1:0] src;
		if (!a[15]) s = {5'b0, ram_bank};   // $6000 window is always RAM
		else begin
			case (prg_mode)
				2'd0: s = {1'b1, bank3[6:2], a[14:13]};
				2'd1: s = a[14] ? {1'b1, bank3[6:1], a[13]} : {prg_bank[1][7:1], a[13]};
				2'd2: begin
					if (!a[14]) s = {prg_bank[1][7:1], a[13]};
					else if (!a[13]) s = prg_bank[2];
					else s = {1'b1, bank3};
				end
				default: s = (a[14:13] == 2'd3) ? {1'b1, bank3} : prg_bank[a[14:13]];
			endcase
		end
		page = s[7] ? {2'b00, s[6:0]} : {6'b111100, s[2:0]};
		e.prg_addr  = {page, a[12:0]};
		e.prg_allow = (a >= 16'h6000) && (!wr || (!s[7] && key1 && key2));
		// Sprite fetch window is cycles 256-319
		set = (spr16 && frame) ? !(cyc[8] && !cyc[6]) : chr_last;
		case (chr_mode)
			2'd0: sel = set ? {chr_bank[11][6:0], ca[12:10]} : {chr_bank[7][6:0], ca[12:10]};
			2'd1: begin
				if (set) sel = {chr_bank[11][7:0], ca[11:10]};
				else if (ca[12]) sel = {chr_bank[7][7:0], ca[11:10]};
				else sel = {chr_bank[3][7:0], ca[11:10]};
			end
			2'd2: begin
				if (set) sel = {(ca[11] ? chr_bank[11][8:0] : chr_bank[9][8:0]), ca[10]};
				else sel = {chr_bank[{ca[12:11], 1'b1}][8:0], ca[10]};
			end
			default: sel = set ? chr_bank[{2'b10, ca[11:10]}] : chr_bank[{1'b0, ca[12:10]}];
		endcase
		e.chr_addr  = {2'b10, sel, ca[9:0]};
		src         = mirroring[{ca[11:10], 1'b0} +: 2];
		e.vram_a10  = src[0];
		e.vram_ce   = ca[13] && !src[1];
		e.chr_valid = ca[13] && src[1];
		e.fill      = frame && (src == 2'd3);
		e.fill_data = cyc[1] ? {4{fill_attr}} : fill_tile;
		return e;
	endfunction

	// Compare process, inputs settled since posedge + 2
	always @(negedge clk) begin
		exp_t e;
		if (cmp_en) begin
			e = ref_mmc5(cpu_addr, cpu_write, chr_addr_in, ppu_in_frame, ppu_sprite16, ppu_cycle);
			check(prg_addr, e.prg_addr, "prg_addr");
			check(prg_allow, e.prg_allow, "prg_allow");
			check(chr_addr, e.chr_addr, "chr_addr");
			check(vram_a10, e.vram_a10, "vram_a10");
			check(vram_ce, e.vram_ce, "vram_ce");
			check(chr_rdata_valid, e.chr_valid, "chr_rdata_valid");
			if (e.fill)
				check(chr_rdata, e.fill_data, "fill byte");
		end
	end

	task automatic reg_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		#2;
		cpu_addr = a;
		cpu_wdata = d;
		cpu_write = 1'b1;
		cpu_read = 1'b0;
		ce = 1'b1;
		@(posedge clk);
		#2;
		ce = 1'b0;
		cpu_write = 1'b0;
		case (a)
			16'h5100: prg_mode = d[1:0];
			16'h5101: chr_mode = d[1:0];
			16'h5102: key1 = (d[1:0] == 2'b10);
			16'h5103: key2 = (d[1:0] == 2'b01);
			16'h5105: mirroring = d;
			16'h5106: fill_tile = d;
			16'h5107: fill_attr = d[1:0];
			16'h5113: ram_bank = d[2:0];
			16'h5114, 16'h5115, 16'h5116: prg_bank[a[1:0]] = d;
			16'h5117: bank3 = d[6:0];   // Bit 7 ignored
			16'h5130: chr_upper = d[1:0];
			16'h5203: irq_line = d;
			16'h5204: irq_en = d[7];
			default: ;
		endcase
		if (a >= 16'h5120 && a <= 16'h512B)
			chr_bank[a[3:0]] = {chr_upper, d};
		if (a[15:4] == 12'h512)
			chr_last = a[3] & ppu_sprite16;   // Set remembered only in 8x16
	endtask

	// Random CPU and PPU levels, checked by the compare process
	task automatic run_random(input int n);
		logic [31:0] r;
		repeat (n) begin
			@(posedge clk);
			#2;
			r = $random(seed);
			cpu_addr = r[15:0];
			cpu_write = r[16];
			ppu_in_frame = r[17];
			ppu_cycle = r[26:18];
			r = $random(seed);
			chr_addr_in = r[13:0];
			cmp_en = 1'b1;
			@(negedge clk);
			#1;
		end
		cmp_en = 1'b0;
		cpu_write = 1'b0;
	endtask

	task automatic set_sprite16(input logic v);
		@(posedge clk);
		#2;
		if (ppu_sprite16 && !v)
			chr_last = 1'b0;   // 8x16 off resets the set
		ppu_sprite16 = v;
		repeat (2) @(posedge clk);
		#2;
	endtask

	initial begin
		logic [7:0]  ma, mb, d;
		logic [15:0] ea;
		logic [31:0] r;
		int          line;
		{ce, cpu_read, cpu_write, cpu_addr, cpu_wdata} = '0;
		{ppu_ce, ppu_in_frame, ppu_sprite16, ppu_cycle, ppu_scanline} = '0;
		{chr_addr_in, chr_write, chr_wdata} = '0;
		{prg_mode, chr_mode, fill_attr, chr_upper} = '0;
		{key1, key2, irq_en, chr_last, mirroring, fill_tile, irq_line, ram_bank} = '0;
		prg_mode = 2'd3;
		bank3 = 7'h7F;
		for (int i = 0; i < 3; i++) prg_bank[i] = '0;
		for (int i = 0; i < 12; i++) chr_bank[i] = '0;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		check(irq, 0, "irq after reset");
		check(cpu_rdata_valid, 0, "read valid after reset");
		run_random(20);   // Reset mapping, writes locked out

		// PRG banking and RAM protect
		for (int i = 0; i < 30; i++) begin
			r = $random(seed);
			reg_write(16'h5100, r[7:0]);
			reg_write(16'h5113, r[15:8]);
			for (int b = 0; b < 4; b++) reg_write(16'h5114 + b, $random(seed));
			reg_write(16'h5102, r[16] ? 8'h02 : r[23:16]);
			reg_write(16'h5103, r[17] ? 8'h01 : r[31:24]);
			run_random(10);
		end

		// CHR banking and nametable quadrants, both sprite sizes
		for (int m = 0; m < 8; m++) begin
			set_sprite16(m[0]);
			reg_write(16'h5101, 8'(m >> 1));
			reg_write(16'h5105, $random(seed));
			reg_write(16'h5106, $random(seed));
			reg_write(16'h5107, $random(seed));
			reg_write(16'h5130, $random(seed));
			for (int b = 0; b < 12; b++) reg_write(16'h5120 + b, $random(seed));
			r = $random(seed);
			reg_write(16'h5120 + 16'(r[7:0] % 12), r[15:8]);   // Picks the last set
			run_random(24);
		end
		set_sprite16(1'b0);

		// Multiplier
		for (int i = 0; i < 10; i++) begin
			ma = $random(seed);
			mb = $random(seed);
			reg_write(16'h5205, ma);
			reg_write(16'h5206, mb);
			@(posedge clk);
			#2;
			cpu_addr = 16'h5205;
			cpu_read = 1'b1;
			@(negedge clk);
			check(cpu_rdata, 8'((16'(ma) * 16'(mb)) & 16'hFF), "product low");
			check(cpu_rdata_valid, 1, "product low valid");
			@(posedge clk);
			#2;
			cpu_addr = 16'h5206;
			@(negedge clk);
			check(cpu_rdata, 8'((16'(ma) * 16'(mb)) >> 8), "product high");
			cpu_read = 1'b0;
		end

		// ExRAM as CPU RAM then read-only
		for (int i = 0; i < 6; i++) begin
			ea = 16'h5C00 | 16'($random(seed) & 32'h3FF);
			d = $random(seed);
			reg_write(16'h5104, 8'h02);
			reg_write(ea, d);
			@(posedge clk);
			#2;
			cpu_addr = ea;
			cpu_read = 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			check(cpu_rdata, d, "ExRAM mode 2 read");
			check(cpu_rdata_valid, 1, "ExRAM read valid");
			reg_write(16'h5104, 8'h03);
			reg_write(ea, ~d);   // Must be dropped
			@(posedge clk);
			#2;
			cpu_addr = ea;
			cpu_read = 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			check(cpu_rdata, d, "ExRAM mode 3 write ignored");
			cpu_read = 1'b0;
		end

		// Scanline IRQ
		line = 10 + ($random(seed) & 32'h7F);
		reg_write(16'h5203, 8'(line));
		reg_write(16'h5204, 8'h80);
		for (int s = 0; s <= line + 2; s++) begin
			@(posedge clk);
			#2;
			ppu_scanline = 9'(s);
			ppu_ce = 1'b1;
			ppu_in_frame = 1'b1;
			@(negedge clk);
			check(irq, irq_en && (s >= irq_line + 2), "irq during sweep");   // Pending then irq
		end
		@(posedge clk);
		#2;
		ppu_ce = 1'b0;
		cpu_addr = 16'h5204;
		cpu_read = 1'b1;
		ce = 1'b1;
		@(negedge clk);
		check(cpu_rdata[7:6], 2'b11, "status with pending");
		@(posedge clk);
		#2;
		ce = 1'b0;
		@(negedge clk);
		check(cpu_rdata[7], 0, "pending cleared by status read");
		@(posedge clk);
		#2;
		@(negedge clk);
		check(irq, 0, "irq after status read");
		for (int s = line - 1; s <= line + 2; s++) begin
			@(posedge clk);
			#2;
			ppu_scanline = 9'(s);
			ppu_ce = 1'b1;
		end
		@(negedge clk);
		check(irq, 1, "irq on second pass");
		@(posedge clk);
		#2;
		ppu_ce = 1'b0;
		ppu_in_frame = 1'b0;
		@(posedge clk);
		#2;
		@(negedge clk);
		check(cpu_rdata[7:6], 2'b00, "pending cleared out of frame");
		@(posedge clk);
		#2;
		@(negedge clk);
		check(irq, 0, "irq out of frame");
		cpu_read = 1'b0;

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- all.f
+incdir+rtl
rtl/mmc5_pkg.sv
rtl/mmc5_regs.sv
rtl/mmc5_prg_map.sv
rtl/mmc5_chr_map.sv
rtl/mmc5_exram.sv
rtl/mmc5_scanline_irq.sv
rtl/mmc5_top.sv
dv/mmc5_asserts.sv
dv/mmc5_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the mapper testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mmc5_tb -f all.f -o mmc5_sim
./obj_dir/mmc5_sim
